//--- all.f
logic/sparcPkg.sv
logic/instructionDecoder.sv
logic/registerWriteDecoder.sv
logic/registerSlot.sv
logic/registerReadCombiner.sv
logic/registerFile.sv
logic/decodeStage.sv
test/decodeStageTb.sv

//--- logic/decodeStage.sv
`default_nettype none
`timescale 1ns/1ps

module decodeStage import sparcPkg::*;
(
    input wire Clk,
    input wire reset,
    input wire [WordWidth-1:0] instr,
    input wire writeEnable,
    input wire [RegAddrWidth-1:0] writeAddr,
    input wire [WordWidth-1:0] writeData,
    input wire [RegAddrWidth-1:0] readAddrA,
    input wire [RegAddrWidth-1:0] readAddrB,
    input wire [RegAddrWidth-1:0] readAddrC,
    output logic jmplInstr,
    output logic storeInstr,
    output logic signExtend,
    output logic loadInstr,
    output logic regWrite,
    output logic modifyCc,
    output logic callInstr,
    output logic branchInstr,
    output logic annul,
    output logic dataMemEnable,
    output aluOp aluSel,
    output memSize accessSize,
    output logic [RegAddrWidth-1:0] destReg,
    output logic [WordWidth-1:0] portA,
    output logic [WordWidth-1:0] portB,
    output logic [WordWidth-1:0] portC
);

    instructionDecoder instructionDecoder_i (
        .instr(instr),
        .jmplInstr(jmplInstr),
        .storeInstr(storeInstr),
        .signExtend(signExtend),
        .loadInstr(loadInstr),
        .regWrite(regWrite),
        .modifyCc(modifyCc),
        .callInstr(callInstr),
        .branchInstr(branchInstr),
        .annul(annul),
        .dataMemEnable(dataMemEnable),
        .aluSel(aluSel),
        .accessSize(accessSize),
        .destReg(destReg)
    );

    registerFile registerFile_i (
        .Clk(Clk),
        .reset(reset),
        .writeEnable(writeEnable),
        .writeAddr(writeAddr),
        .writeData(writeData),
        .readAddrA(readAddrA),
        .readAddrB(readAddrB),
        .readAddrC(readAddrC),
        .portA(portA),
        .portB(portB),
        .portC(portC)
    );

endmodule

`default_nettype wire

//--- logic/instructionDecoder.sv
`default_nettype none
`timescale 1ns/1ps

module instructionDecoder import sparcPkg::*;
(
    input wire [WordWidth-1:0] instr,
    output logic jmplInstr,
    output logic storeInstr,
    output logic signExtend,
    output logic loadInstr,
    output logic regWrite,
    output logic modifyCc,
    output logic callInstr,
    output logic branchInstr,
    output logic annul,
    output logic dataMemEnable,
    output aluOp aluSel,
    output memSize accessSize,
    output logic [RegAddrWidth-1:0] destReg
);

    instrFormat format;
    logic [5:0] op3;        // Bits 24-19
    logic [3:0] arithCode;  // Low four bits of op3

    assign format = instrFormat'(instr[31:30]);
    assign op3 = instr[24:19];
    assign arithCode = instr[22:19];

    always_comb
    begin
        jmplInstr = 1'b0;
        storeInstr = 1'b0;
        signExtend = 1'b0;
        loadInstr = 1'b0;
        regWrite = 1'b0;
        modifyCc = 1'b0;
        callInstr = 1'b0;
        branchInstr = 1'b0;
        annul = 1'b0;
        dataMemEnable = 1'b0;
        aluSel = aluAdd;
        accessSize = sizeByte;
        destReg = instr[29:25];  // rd field

        case (format)
            fmtCall:
            begin
                callInstr = 1'b1;
                regWrite = 1'b1;
                destReg = LinkReg;  // Return address goes to r15
            end
            fmtBranch:
            begin
                if (instr == '0)
                begin
                    // Nop keeps all defaults
                end
                else if (instr[24:22] != 3'd4)
                begin
                    branchInstr = 1'b1;
                    annul = instr[29];  // Annul bit
                end
                else
                begin
                    regWrite = 1'b1;  // SETHI
                    aluSel = aluPassB;
                end
            end
            fmtArith:
            begin
                regWrite = 1'b1;
                if (op3 == 6'd56)
                begin
                    jmplInstr = 1'b1;  // Target = rs1 + operand2
                    aluSel = aluAdd;
                end
                else
                begin
                    modifyCc = instr[23];  // The cc variants set bit 23
                    case (arithCode)
                        4'd0: aluSel = aluAdd;
                        4'd8: aluSel = aluAddc;
                        4'd4: aluSel = aluSub;
                        4'd12: aluSel = aluSubc;
                        4'd1: aluSel = aluAnd;
                        4'd2: aluSel = aluOr;
                        4'd3: aluSel = aluXor;
                        4'd5: aluSel = instr[24] ? aluSll : aluAndn;
                        4'd6: aluSel = instr[24] ? aluSrl : aluOrn;
                        4'd7: aluSel = instr[24] ? aluSra : aluXnor;
                        default: aluSel = aluAdd;  // Unlisted codes fall back to Add
                    endcase
                end
            end
            fmtMemory:
            begin
                dataMemEnable = 1'b1;
                case (op3)
                    6'd9:
                    begin
                        loadInstr = 1'b1;  // LDSB
                        signExtend = 1'b1;
                        accessSize = sizeByte;
                    end
                    6'd10:
                    begin
                        loadInstr = 1'b1;  // LDSH
                        signExtend = 1'b1;
                        accessSize = sizeHalf;
                    end
                    6'd0:
                    begin
                        loadInstr = 1'b1;
                        accessSize = sizeWord;
                    end
                    6'd1: loadInstr = 1'b1;  // LDUB
                    6'd2:
                    begin
                        loadInstr = 1'b1;  // LDUH
                        accessSize = sizeHalf;
                    end
                    6'd5: storeInstr = 1'b1;  // STB
                    6'd6:
                    begin
                        storeInstr = 1'b1;
                        accessSize = sizeHalf;
                    end
                    6'd4:
                    begin
                        storeInstr = 1'b1;
                        accessSize = sizeWord;
                    end
                    default: accessSize = sizeByte;  // Neither load nor store
                endcase
                regWrite = loadInstr;  // Only loads write back
            end
        endcase
    end

endmodule

`default_nettype wire

//--- logic/registerFile.sv
`default_nettype none
`timescale 1ns/1ps

module registerFile import sparcPkg::*;
(
    input wire Clk,
    input wire reset,
    input wire writeEnable,
    input wire [RegAddrWidth-1:0] writeAddr,
    input wire [WordWidth-1:0] writeData,
    input wire [RegAddrWidth-1:0] readAddrA,
    input wire [RegAddrWidth-1:0] readAddrB,
    input wire [RegAddrWidth-1:0] readAddrC,
    output logic [WordWidth-1:0] portA,
    output logic [WordWidth-1:0] portB,
    output logic [WordWidth-1:0] portC
);

    logic [RegCount-1:0] slotWrite;
    wire [WordWidth-1:0] slotA [RegCount];
    wire [WordWidth-1:0] slotB [RegCount];
    wire [WordWidth-1:0] slotC [RegCount];

    registerWriteDecoder registerWriteDecoder_i (
        .writeEnable(writeEnable),
        .writeAddr(writeAddr),
        .slotWrite(slotWrite)
    );

    // r0 has no storage
    assign slotA[0] = '0;
    assign slotB[0] = '0;
    assign slotC[0] = '0;

    for (genvar i = 1; i < RegCount; i++)
    begin : gSlot
        registerSlot #(.SlotIndex(i)) registerSlot_i (
            .Clk(Clk),
            .reset(reset),
            .write(slotWrite[i]),
            .writeData(writeData),
            .readAddrA(readAddrA),
            .readAddrB(readAddrB),
            .readAddrC(readAddrC),
            .slotA(slotA[i]),
            .slotB(slotB[i]),
            .slotC(slotC[i])
        );
    end

    registerReadCombiner registerReadCombiner_i (
        .slotA(slotA),
        .slotB(slotB),
        .slotC(slotC),
        .portA(portA),
        .portB(portB),
        .portC(portC)
    );

endmodule

`default_nettype wire

//--- logic/registerReadCombiner.sv
`default_nettype none
`timescale 1ns/1ps

module registerReadCombiner import sparcPkg::*;
(
    input wire [WordWidth-1:0] slotA [RegCount],
    input wire [WordWidth-1:0] slotB [RegCount],
    input wire [WordWidth-1:0] slotC [RegCount],
    output logic [WordWidth-1:0] portA,
    output logic [WordWidth-1:0] portB,
    output logic [WordWidth-1:0] portC
);

    // At most one slot per port is nonzero, so OR acts as the mux
    always_comb
    begin
        portA = '0;
        portB = '0;
        portC = '0;
        for (int i = 0; i < RegCount; i++)
        begin
            portA = portA | slotA[i];
            portB = portB | slotB[i];
            portC = portC | slotC[i];
        end
    end

endmodule

`default_nettype wire

//--- logic/registerSlot.sv
`default_nettype none
`timescale 1ns/1ps

module registerSlot import sparcPkg::*;
#(
    parameter int SlotIndex = 1  // Register number from 1 to RegCount-1
)
(
    input wire Clk,
    input wire reset,
    input wire write,
    input wire [WordWidth-1:0] writeData,
    input wire [RegAddrWidth-1:0] readAddrA,
    input wire [RegAddrWidth-1:0] readAddrB,
    input wire [RegAddrWidth-1:0] readAddrC,
    output logic [WordWidth-1:0] slotA,
    output logic [WordWidth-1:0] slotB,
    output logic [WordWidth-1:0] slotC
);

    logic [WordWidth-1:0] word;

    always_ff @(posedge Clk)
    begin
        if (reset)
            word <= '0;
        else if (write)
            word <= writeData;
    end

    // Present the word only on ports that address this slot
    assign slotA = (readAddrA == RegAddrWidth'(SlotIndex)) ? word : '0;
    assign slotB = (readAddrB == RegAddrWidth'(SlotIndex)) ? word : '0;
    assign slotC = (readAddrC == RegAddrWidth'(SlotIndex)) ? word : '0;

endmodule

`default_nettype wire

//--- logic/registerWriteDecoder.sv
`default_nettype none
`timescale 1ns/1ps

module registerWriteDecoder import sparcPkg::*;
(
    input wire writeEnable,
    input wire [RegAddrWidth-1:0] writeAddr,
    output logic [RegCount-1:0] slotWrite
);

    // One-hot write strobe per register
    always_comb
    begin
        slotWrite = '0;
        if (writeEnable && writeAddr != ZeroReg)
        begin
            slotWrite[writeAddr] = 1'b1;  // r0 stays read-only
        end
    end

endmodule

`default_nettype wire

//--- logic/sparcPkg.sv
`default_nettype none

package sparcPkg;

    localparam int WordWidth = 32;     // Data and instruction width
    localparam int RegAddrWidth = 5;
    localparam int RegCount = 32;      // General registers incl. r0

    localparam logic [RegAddrWidth-1:0] ZeroReg = 5'd0;   // Hardwired zero
    localparam logic [RegAddrWidth-1:0] LinkReg = 5'd15;  // Return address of CALL

    // Top two bits of the instruction word
    typedef enum logic [1:0]
    {
        fmtBranch = 2'd0,   // Branch, SETHI, nop
        fmtCall   = 2'd1,
        fmtArith  = 2'd2,   // Arithmetic, logic, shifts, JMPL
        fmtMemory = 2'd3    // Loads and stores
    } instrFormat;

    typedef enum logic [3:0]
    {
        aluAdd   = 4'd0,
        aluAddc  = 4'd1,
        aluSub   = 4'd2,
        aluSubc  = 4'd3,
        aluAnd   = 4'd4,
        aluOr    = 4'd5,
        aluXor   = 4'd6,
        aluXnor  = 4'd7,
        aluAndn  = 4'd8,
        aluOrn   = 4'd9,
        aluSll   = 4'd10,
        aluSrl   = 4'd11,
        aluSra   = 4'd12,
        aluPassB = 4'd14    // Operand B straight through for SETHI
    } aluOp;

    typedef enum logic [1:0]
    {
        sizeByte = 2'd0,
        sizeHalf = 2'd1,
        sizeWord = 2'd2
    } memSize;

endpackage

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass message in the output
cd "$(dirname "$0")" &&
verilator --binary --timing -f all.f --top-module decodeStageTb &&
./obj_dir/VdecodeStageTb | tee /dev/stderr | grep -q "Everything OK" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

//--- test/decodeStageTb.sv
`default_nettype none
`timescale 1ns/1ps

module decodeStageTb import sparcPkg::*;
();

    // Control flag positions in the expected-value table
    localparam logic [9:0] fJmpl = 10'b1000000000;
    localparam logic [9:0] fStore = 10'b0100000000;
    localparam logic [9:0] fSignExt = 10'b0010000000;
    localparam logic [9:0] fLoad = 10'b0001000000;
    localparam logic [9:0] fRegWrite = 10'b0000100000;
    localparam logic [9:0] fModCc = 10'b0000010000;
    localparam logic [9:0] fCall = 10'b0000001000;
    localparam logic [9:0] fBranch = 10'b0000000100;
    localparam logic [9:0] fAnnul = 10'b0000000010;
    localparam logic [9:0] fMemEn = 10'b0000000001;

    typedef struct packed
    {
        logic [31:0] instr;
        logic [9:0] flags;
        aluOp alu;
        memSize size;
        logic [4:0] dest;
    } decodeRow;

    typedef struct packed
    {
        logic wen;
        logic [4:0] waddr;
        logic [4:0] ra;
        logic [4:0] rb;
        logic [4:0] rc;
        logic sameCycle;  // Also check the old value during the write cycle
    } regRow;

    logic Clk = 1'b0;
    logic reset;
    logic [WordWidth-1:0] instr;
    logic writeEnable;
    logic [RegAddrWidth-1:0] writeAddr;
    logic [WordWidth-1:0] writeData;
    logic [RegAddrWidth-1:0] readAddrA;
    logic [RegAddrWidth-1:0] readAddrB;
    logic [RegAddrWidth-1:0] readAddrC;
    logic jmplInstr;
    logic storeInstr;
    logic signExtend;
    logic loadInstr;
    logic regWrite;
    logic modifyCc;
    logic callInstr;
    logic branchInstr;
    logic annul;
    logic dataMemEnable;
    aluOp aluSel;
    memSize accessSize;
    logic [RegAddrWidth-1:0] destReg;
    logic [WordWidth-1:0] portA;
    logic [WordWidth-1:0] portB;
    logic [WordWidth-1:0] portC;

    decodeRow decodeTable [$];
    regRow regTable [$];
    logic [WordWidth-1:0] model [RegCount];  // Expected register contents
    logic [15:0] lfsrState;
    int errors = 0;
    int checks = 0;
    int cycles = 0;
    int cycleLimit = 0;

    decodeStage decodeStage_i (.*);

    always #5 Clk = ~Clk;

    always @(posedge Clk)
    begin
        cycles = cycles + 1;
        if (cycleLimit != 0 && cycles >= cycleLimit)
        begin
            $display("Timeout after %0d cycles, the tests did not finish", cycles);
            $display("Something failed");
            $finish;
        end
    end

    // x^16 + x^14 + x^13 + x^11
    function automatic logic lfsrBit();
        logic feedback;
        feedback = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
        lfsrState = {lfsrState[14:0], feedback};
        return feedback;
    endfunction

    function automatic logic [31:0] randomWord();
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < 32; i++)
            w = {w[30:0], lfsrBit()};
        return w;
    endfunction

    function automatic logic [31:0] makeInstr(input logic [1:0] fmt, input logic [4:0] rd,
                                              input logic [5:0] op3, input logic [18:0] low);
        return {fmt, rd, op3, low};
    endfunction

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("FAIL t=%0t %s: got %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic addDecode(input logic [31:0] word, input logic [9:0] flags, input aluOp alu,
                             input memSize size, input logic [4:0] dest);
        decodeRow row;
        row = '{instr: word, flags: flags, alu: alu, size: size, dest: dest};
        decodeTable.push_back(row);
    endtask

    task automatic addReg(input logic wen, input logic [4:0] waddr, input logic [4:0] ra,
                          input logic [4:0] rb, input logic [4:0] rc, input logic sameCycle);
        regRow row;
        row = '{wen: wen, waddr: waddr, ra: ra, rb: rb, rc: rc, sameCycle: sameCycle};
        regTable.push_back(row);
    endtask

    task automatic fillTables();
        addDecode(32'h0, 10'b0, aluAdd, sizeByte, 5'd0);  // Nop
        addDecode(makeInstr(2'd1, 5'd3, 6'd12, 19'h1), fCall | fRegWrite, aluAdd, sizeByte, 5'd15);
        addDecode(makeInstr(2'd0, 5'd8, 6'o20, 19'h40), fBranch, aluAdd, sizeByte, 5'd8);
        addDecode(makeInstr(2'd0, 5'd24, 6'o20, 19'h40), fBranch | fAnnul, aluAdd, sizeByte,
                  5'd24);
        addDecode(makeInstr(2'd0, 5'd3, 6'o40, 19'h1234), fRegWrite, aluPassB, sizeByte, 5'd3);
        addDecode(makeInstr(2'd2, 5'd7, 6'd56, 19'h8), fJmpl | fRegWrite, aluAdd, sizeByte, 5'd7);
        addDecode(makeInstr(2'd2, 5'd1, 6'd0, 19'h5), fRegWrite, aluAdd, sizeByte, 5'd1);
        addDecode(makeInstr(2'd2, 5'd2, 6'd8, 19'h5), fRegWrite, aluAddc, sizeByte, 5'd2);
        addDecode(makeInstr(2'd2, 5'd3, 6'd4, 19'h5), fRegWrite, aluSub, sizeByte, 5'd3);
        addDecode(makeInstr(2'd2, 5'd4, 6'd12, 19'h5), fRegWrite, aluSubc, sizeByte, 5'd4);
        addDecode(makeInstr(2'd2, 5'd5, 6'd1, 19'h5), fRegWrite, aluAnd, sizeByte, 5'd5);
        addDecode(makeInstr(2'd2, 5'd6, 6'd2, 19'h5), fRegWrite, aluOr, sizeByte, 5'd6);
        addDecode(makeInstr(2'd2, 5'd9, 6'd3, 19'h5), fRegWrite, aluXor, sizeByte, 5'd9);
        addDecode(makeInstr(2'd2, 5'd10, 6'd5, 19'h5), fRegWrite, aluAndn, sizeByte, 5'd10);
        addDecode(makeInstr(2'd2, 5'd11, 6'd6, 19'h5), fRegWrite, aluOrn, sizeByte, 5'd11);
        addDecode(makeInstr(2'd2, 5'd12, 6'd7, 19'h5), fRegWrite, aluXnor, sizeByte, 5'd12);
        addDecode(makeInstr(2'd2, 5'd13, 6'd37, 19'h5), fRegWrite, aluSll, sizeByte, 5'd13);
        addDecode(makeInstr(2'd2, 5'd14, 6'd38, 19'h5), fRegWrite, aluSrl, sizeByte, 5'd14);
        addDecode(makeInstr(2'd2, 5'd16, 6'd39, 19'h5), fRegWrite, aluSra, sizeByte, 5'd16);
        addDecode(makeInstr(2'd2, 5'd17, 6'd16, 19'h5), fRegWrite | fModCc, aluAdd, sizeByte,
                  5'd17);  // ADDcc
        addDecode(makeInstr(2'd2, 5'd18, 6'd20, 19'h5), fRegWrite | fModCc, aluSub, sizeByte,
                  5'd18);  // SUBcc
        addDecode(makeInstr(2'd2, 5'd19, 6'd9, 19'h5), fRegWrite, aluAdd, sizeByte, 5'd19);
        addDecode(makeInstr(2'd3, 5'd20, 6'd9, 19'h2), fMemEn | fLoad | fRegWrite | fSignExt,
                  aluAdd, sizeByte, 5'd20);
        addDecode(makeInstr(2'd3, 5'd21, 6'd10, 19'h2), fMemEn | fLoad | fRegWrite | fSignExt,
                  aluAdd, sizeHalf, 5'd21);
        addDecode(makeInstr(2'd3, 5'd22, 6'd0, 19'h2), fMemEn | fLoad | fRegWrite, aluAdd,
                  sizeWord, 5'd22);
        addDecode(makeInstr(2'd3, 5'd23, 6'd1, 19'h2), fMemEn | fLoad | fRegWrite, aluAdd,
                  sizeByte, 5'd23);
        addDecode(makeInstr(2'd3, 5'd25, 6'd2, 19'h2), fMemEn | fLoad | fRegWrite, aluAdd,
                  sizeHalf, 5'd25);
        addDecode(makeInstr(2'd3, 5'd26, 6'd5, 19'h2), fMemEn | fStore, aluAdd, sizeByte, 5'd26);
        addDecode(makeInstr(2'd3, 5'd27, 6'd6, 19'h2), fMemEn | fStore, aluAdd, sizeHalf, 5'd27);
        addDecode(makeInstr(2'd3, 5'd28, 6'd4, 19'h2), fMemEn | fStore, aluAdd, sizeWord, 5'd28);
        addDecode(makeInstr(2'd3, 5'd29, 6'd3, 19'h2), fMemEn, aluAdd, sizeByte, 5'd29);

        addReg(1'b1, 5'd1, 5'd1, 5'd0, 5'd31, 1'b1);
        addReg(1'b1, 5'd31, 5'd31, 5'd1, 5'd2, 1'b0);
        addReg(1'b1, 5'd2, 5'd2, 5'd31, 5'd1, 1'b1);
        addReg(1'b1, 5'd17, 5'd17, 5'd2, 5'd1, 1'b0);
        addReg(1'b1, 5'd1, 5'd1, 5'd17, 5'd31, 1'b1);  // Overwrite of a nonzero value
        addReg(1'b1, 5'd30, 5'd30, 5'd29, 5'd17, 1'b1);
        addReg(1'b1, 5'd29, 5'd29, 5'd30, 5'd0, 1'b0);
        addReg(1'b1, 5'd15, 5'd15, 5'd16, 5'd14, 1'b1);
        addReg(1'b1, 5'd16, 5'd16, 5'd15, 5'd31, 1'b0);
        addReg(1'b1, 5'd0, 5'd0, 5'd1, 5'd2, 1'b1);    // r0 stays zero
        addReg(1'b0, 5'd5, 5'd5, 5'd1, 5'd17, 1'b1);   // Strobe low
        addReg(1'b0, 5'd17, 5'd17, 5'd16, 5'd15, 1'b1);
        addReg(1'b1, 5'd5, 5'd5, 5'd17, 5'd0, 1'b1);
    endtask

    task automatic checkPorts(input logic [4:0] ra, input logic [4:0] rb, input logic [4:0] rc);
        checkValue($sformatf("portA (r%0d)", ra), portA, model[ra]);
        checkValue($sformatf("portB (r%0d)", rb), portB, model[rb]);
        checkValue($sformatf("portC (r%0d)", rc), portC, model[rc]);
    endtask

    task automatic sweepPorts();
        for (int a = 0; a < RegCount; a++)
        begin
            @(posedge Clk);
            readAddrA <= 5'(a);
            readAddrB <= 5'((a + 1) % RegCount);
            readAddrC <= 5'((a + 2) % RegCount);
            @(negedge Clk);
            checkPorts(5'(a), 5'((a + 1) % RegCount), 5'((a + 2) % RegCount));
        end
    endtask

    task automatic applyDecode(input decodeRow row);
        @(posedge Clk);
        instr <= row.instr;
        @(negedge Clk);
        checkValue("jmplInstr", 32'(jmplInstr), 32'(row.flags[9]));
        checkValue("storeInstr", 32'(storeInstr), 32'(row.flags[8]));
        checkValue("signExtend", 32'(signExtend), 32'(row.flags[7]));
        checkValue("loadInstr", 32'(loadInstr), 32'(row.flags[6]));
        checkValue("regWrite", 32'(regWrite), 32'(row.flags[5]));
        checkValue("modifyCc", 32'(modifyCc), 32'(row.flags[4]));
        checkValue("callInstr", 32'(callInstr), 32'(row.flags[3]));
        checkValue("branchInstr", 32'(branchInstr), 32'(row.flags[2]));
        checkValue("annul", 32'(annul), 32'(row.flags[1]));
        checkValue("dataMemEnable", 32'(dataMemEnable), 32'(row.flags[0]));
        checkValue("aluSel", 32'(aluSel), 32'(row.alu));
        checkValue("accessSize", 32'(accessSize), 32'(row.size));
        checkValue("destReg", 32'(destReg), 32'(row.dest));
    endtask

    task automatic applyReg(input regRow row);
        logic [31:0] data;
        data = randomWord();
        @(posedge Clk);
        writeEnable <= row.wen;
        writeAddr <= row.waddr;
        writeData <= data;
        readAddrA <= row.ra;
        readAddrB <= row.rb;
        readAddrC <= row.rc;
        @(negedge Clk);
        if (row.sameCycle)
            checkPorts(row.ra, row.rb, row.rc);  // No bypass so the old contents show
        @(posedge Clk);
        writeEnable <= 1'b0;
        if (row.wen && row.waddr != 5'd0)
            model[row.waddr] = data;
        @(negedge Clk);
        checkPorts(row.ra, row.rb, row.rc);
    endtask

    initial
    begin
        reset = 1'b1;
        instr = '0;
        writeEnable = 1'b0;
        writeAddr = '0;
        writeData = '0;
        readAddrA = '0;
        readAddrB = '0;
        readAddrC = '0;
        lfsrState = 16'd33835;
        for (int i = 0; i < RegCount; i++)
            model[i] = '0;
        fillTables();
        // One cycle per decode row and per swept address and two per register row
        cycleLimit = 2 * (decodeTable.size() + 2 * regTable.size() + 2 * RegCount + 2) + 20;

        repeat (4) @(posedge Clk);
        reset <= 1'b0;

        sweepPorts();

        foreach (decodeTable[i])
            applyDecode(decodeTable[i]);
        foreach (regTable[i])
            applyReg(regTable[i]);

        @(posedge Clk);
        reset <= 1'b1;  // Clear the written registers again
        @(posedge Clk);
        reset <= 1'b0;
        for (int i = 0; i < RegCount; i++)
            model[i] = '0;
        sweepPorts();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire
